/* hw/mem_pkg.sv */
`default_nettype none

package mem_pkg;

   // ------------------------------------------------------------
   // widths and fixed locations
   // ------------------------------------------------------------
   localparam int RAM_AW     = 21;                 // 2 MB external sram
   localparam int CPU_AW     = 16;
   localparam int QUAD_AW    = 14;                 // 16 KB per quadrant
   localparam int PAGE_W     = RAM_AW - QUAD_AW;   // 128 pages of 16 KB
   localparam int SLOT_COUNT = 4;

   // register indexes on the core register interface
   localparam logic [7:0] MASTERCONF_ADDR   = 8'h00;
   localparam logic [7:0] MASTERMAPPER_ADDR = 8'h01;

   localparam logic [PAGE_W-1:0] ROM_BASE_PAGE = PAGE_W'(8);  // roms live in pages 8..11
   localparam logic [3:0]        TIMEX_BASE    = 4'b0011;      // doc/ext area, 64 KB x 2
   localparam logic [7:0]        IDLE_DATA     = 8'hFF;        // floating bus value

   // ------------------------------------------------------------
   // enums
   // ------------------------------------------------------------
   // +3 special paging, named after the pages seen in slots 0..3
   typedef enum logic [1:0] {
      CFG_0123 = 2'b00,
      CFG_4567 = 2'b01,
      CFG_4563 = 2'b10,
      CFG_4763 = 2'b11
   } allram_cfg_e;

   typedef enum logic [1:0] {
      PORT_NONE  = 2'b00,
      PORT_7FFD  = 2'b01,
      PORT_1FFD  = 2'b10,
      PORT_TIMEX = 2'b11   // $f4 mmu
   } io_port_e;

   // ------------------------------------------------------------
   // bundles
   // ------------------------------------------------------------
   typedef struct packed {
      logic [CPU_AW-1:0] a;
      logic [7:0]        din;      // cpu data out
      logic              mreq_n;
      logic              iorq_n;
      logic              rd_n;
      logic              wr_n;
   } cpu_bus_t;

   typedef struct packed {
      logic [7:0] addr;   // selected register index
      logic       ior;
      logic       iow;
   } zxreg_t;

   typedef struct packed {
      logic disable_7ffd;
      logic disable_1ffd;
      logic disable_romsel7f;
      logic disable_romsel1f;
      logic enable_timexmmu;
      logic doc_ext_option;   // picks doc or ext bank in timex area
   } mem_opts_t;

   typedef struct packed {
      logic              boot_mode;
      logic [2:0]        ram_bank;     // $c000 bank from $7ffd
      logic [1:0]        ext_bank;     // pentagon 512K high bits
      logic [1:0]        rom_sel;      // already masked by the option gates
      logic              allram;
      allram_cfg_e       allram_cfg;
      logic [7:0]        timex_mmu;    // one bit per 8 KB half
      logic [PAGE_W-1:0] mastermapper;
   } paging_t;

   typedef struct packed {
      logic              hit;
      logic [RAM_AW-1:0] ram_addr;
      logic              wr_ok;
      logic              contended;   // ula screen contention
   } slot_map_t;

endpackage

`default_nettype wire

/* hw/paging_regs.sv */
`default_nettype none

module paging_regs (
   input  logic                clk,
   input  logic                mrst_n,
   input  mem_pkg::cpu_bus_t   bus,
   input  mem_pkg::zxreg_t     zreg,
   input  mem_pkg::mem_opts_t  opts,
   output mem_pkg::paging_t    pg,
   output logic [7:0]          rdback,
   output logic                rdback_vld,
   output logic [1:0]          timing_mode,
   output logic                disable_contention,
   output logic                issue2_keyboard_enabled,
   output logic                in_boot_mode,
   output logic                in48kmode
);
   import mem_pkg::*;

   io_port_e          port;          // decoded io target
   logic              io_wr;
   logic              io_rd;
   logic [7:0]        bank128;       // $7ffd
   logic [2:0]        bankplus3;     // $1ffd, only the paging bits
   logic [7:0]        timex_mmu;     // $f4
   logic [7:0]        masterconf;
   logic [PAGE_W-1:0] mastermapper;
   logic              locked;
   logic              frozen;
   logic              mc_wr;
   logic              mm_wr;

   assign io_wr  = !bus.iorq_n && !bus.wr_n;
   assign io_rd  = !bus.iorq_n && !bus.rd_n;
   assign locked = bank128[5];          // 48K lock
   assign frozen = masterconf[7];
   assign mc_wr  = zreg.iow && zreg.addr == MASTERCONF_ADDR;
   assign mm_wr  = zreg.iow && zreg.addr == MASTERMAPPER_ADDR;

   // ------------------------------------------------------------
   // port decode, +2A style when both ports are on, else 128K
   // ------------------------------------------------------------
   always_comb begin
      port = PORT_NONE;
      if (opts.enable_timexmmu && bus.a[7:0] == 8'hF4) begin
         port = PORT_TIMEX;                      // $f4 wins over the partial decodes
      end else if (!bus.a[1] && !opts.disable_7ffd) begin
         if (!opts.disable_1ffd) begin
            if (bus.a[15:12] == 4'b0001)
               port = PORT_1FFD;
            else if (bus.a[15:14] == 2'b01)
               port = PORT_7FFD;
         end else if (!bus.a[15]) begin
            port = PORT_7FFD;                    // plain 128K, a15 = 0 and a1 = 0
         end
      end
   end

   // paging ports, level strobed so din loads on every edge of the write
   always_ff @(posedge clk) begin
      if (!mrst_n) begin
         bank128   <= '0;
         bankplus3 <= '0;
         timex_mmu <= '0;
      end else if (io_wr) begin
         case (port)
            PORT_7FFD:  if (!locked) bank128 <= bus.din;
            PORT_1FFD:  if (!locked) bankplus3 <= bus.din[2:0];
            PORT_TIMEX: timex_mmu <= bus.din;   // lock does not touch the mmu
            default: ;
         endcase
      end
   end

   // ------------------------------------------------------------
   // master configuration and master mapper
   // ------------------------------------------------------------
   // layout  7 freeze, 6 tm1, 5 nocont, 4 tm0, 3 issue2, 2..1 spare, 0 boot
   always_ff @(posedge clk) begin
      if (!mrst_n) begin
         masterconf  <= 8'h01;     // boot mode on, nothing frozen
         timing_mode <= 2'b01;     // 128K timing until software picks one
      end else if (mc_wr) begin
         masterconf[6:1] <= bus.din[6:1];
         timing_mode     <= {bus.din[6], bus.din[4]};
         if (!frozen) begin
            masterconf[7] <= bus.din[7];
            masterconf[0] <= bus.din[0];   // leaving boot mode is one-way once frozen
         end
      end
   end

   always_ff @(posedge clk) begin
      if (!mrst_n)
         mastermapper <= '0;
      else if (mm_wr && masterconf[0])   // only reachable from boot code
         mastermapper <= bus.din[PAGE_W-1:0];
   end

   // ------------------------------------------------------------
   // outputs
   // ------------------------------------------------------------
   always_comb begin
      pg.boot_mode    = masterconf[0];
      pg.ram_bank     = bank128[2:0];
      pg.ext_bank     = bank128[7:6];
      pg.rom_sel      = {bankplus3[2] & ~opts.disable_romsel1f,
                         bank128[4]   & ~opts.disable_romsel7f};
      pg.allram       = bankplus3[0];
      pg.allram_cfg   = allram_cfg_e'(bankplus3[2:1]);
      pg.timex_mmu    = timex_mmu;
      pg.mastermapper = mastermapper;
   end

   assign disable_contention      = masterconf[5];
   assign issue2_keyboard_enabled = masterconf[3];
   assign in_boot_mode            = ~frozen;
   assign in48kmode               = locked | opts.disable_7ffd;

   // readback, cpu port read of $f4 first, then the register interface
   always_comb begin
      rdback     = IDLE_DATA;
      rdback_vld = 1'b0;
      if (io_rd && port == PORT_TIMEX) begin
         rdback     = timex_mmu;
         rdback_vld = 1'b1;
      end else if (zreg.ior && zreg.addr == MASTERCONF_ADDR) begin
         rdback     = masterconf;
         rdback_vld = 1'b1;
      end else if (zreg.ior && zreg.addr == MASTERMAPPER_ADDR) begin
         rdback     = {1'b0, mastermapper};
         rdback_vld = 1'b1;
      end
   end

   // the 48K lock sticks until the master reset
   a_lock_holds : assert property (@(posedge clk) disable iff (!mrst_n)
      locked |=> $stable(bank128))
      else $error("bank128 changed while locked");

endmodule

`default_nettype wire

/* hw/quadrant_mapper.sv */
`default_nettype none

module quadrant_mapper #(
   parameter int SLOT          = 0,      // quadrant index, 0 = $0000
   parameter bit PENTAGON_512K = 1'b0
) (
   input  mem_pkg::cpu_bus_t   bus,
   input  mem_pkg::paging_t    pg,
   input  mem_pkg::mem_opts_t  opts,
   input  logic                inhibit_rom,
   output mem_pkg::slot_map_t  map
);
   import mem_pkg::*;

   localparam logic [1:0] SLOT_ID = SLOT[1:0];

   logic              slot_sel;    // a15..a14 point at this quadrant
   logic              half;        // upper 8 KB of the quadrant
   logic              timex_ovr;
   logic              is_rom;
   logic [PAGE_W-1:0] page;
   logic [PAGE_W-1:0] bank_page;

   assign slot_sel  = bus.a[CPU_AW-1 -: 2] == SLOT_ID;
   assign half      = bus.a[QUAD_AW-1];
   assign timex_ovr = !pg.boot_mode && pg.timex_mmu[{SLOT_ID, half}];

   // $c000 bank from $7ffd, pentagon adds two high bits
   assign bank_page = PENTAGON_512K ? {pg.ext_bank, 2'b00, pg.ram_bank}
                                    : {4'b0000, pg.ram_bank};

   // ------------------------------------------------------------
   // page select, boot first, then +3 all-ram, then normal
   // ------------------------------------------------------------
   always_comb begin
      page   = '0;
      is_rom = 1'b0;
      if (pg.boot_mode) begin
         case (SLOT_ID)
            2'd1:    page = PAGE_W'(5);
            2'd2:    page = PAGE_W'(2);
            2'd3:    page = pg.mastermapper;     // boot code picks any page here
            default: page = '0;                  // rom space unused while booting
         endcase
      end else if (pg.allram) begin
         case (SLOT_ID)
            2'd0:    page = (pg.allram_cfg == CFG_0123) ? PAGE_W'(0) : PAGE_W'(4);
            2'd1: begin
               if (pg.allram_cfg == CFG_0123)
                  page = PAGE_W'(1);
               else if (pg.allram_cfg == CFG_4763)
                  page = PAGE_W'(7);
               else
                  page = PAGE_W'(5);
            end
            2'd2:    page = (pg.allram_cfg == CFG_0123) ? PAGE_W'(2) : PAGE_W'(6);
            default: page = (pg.allram_cfg == CFG_4567) ? PAGE_W'(7) : PAGE_W'(3);
         endcase
      end else begin
         case (SLOT_ID)
            2'd0: begin
               page   = ROM_BASE_PAGE + PAGE_W'(pg.rom_sel);   // one of four roms
               is_rom = 1'b1;
            end
            2'd1:    page = PAGE_W'(5);
            2'd2:    page = PAGE_W'(2);
            default: page = bank_page;
         endcase
      end
   end

   // ------------------------------------------------------------
   // slot result
   // ------------------------------------------------------------
   always_comb begin
      map.hit = !bus.mreq_n && slot_sel;
      if (SLOT_ID == 2'd0)
         map.hit = map.hit && !pg.boot_mode && !inhibit_rom;   // external rom owns it

      // timex override puts the 8 KB half into doc or ext
      if (timex_ovr)
         map.ram_addr = {TIMEX_BASE, opts.doc_ext_option, SLOT_ID, bus.a[QUAD_AW-1:0]};
      else
         map.ram_addr = {page, bus.a[QUAD_AW-1:0]};

      map.wr_ok = timex_ovr || !is_rom;     // doc/ext is ram even over the rom

      // screen pages 5 and odd banks are contended, not doc/ext or all-ram
      map.contended = slot_sel && !pg.boot_mode && !timex_ovr && !pg.allram &&
                      (SLOT_ID == 2'd1 || (SLOT_ID == 2'd3 && pg.ram_bank[0]));
   end

endmodule

`default_nettype wire

/* hw/bus_select.sv */
`default_nettype none

module bus_select (
   input  mem_pkg::cpu_bus_t           bus,
   input  mem_pkg::zxreg_t             zreg,
   input  mem_pkg::slot_map_t          maps [mem_pkg::SLOT_COUNT],
   input  logic [7:0]                  rdback,
   input  logic                        rdback_vld,
   input  logic                        boot_mode,
   input  logic                        inhibit_rom,
   input  logic [7:0]                  din_external,
   input  logic [7:0]                  ram_d,
   output logic [mem_pkg::RAM_AW-1:0]  ram_a,
   output logic                        ram_rd_n,
   output logic                        ram_wr_n,
   output logic [7:0]                  ram_q,
   output logic [7:0]                  dout,
   output logic                        oe,
   output logic                        access_to_screen
);
   import mem_pkg::*;

   logic [SLOT_COUNT-1:0] hits;         // one bit per quadrant
   logic [RAM_AW-1:0]     hit_addr;
   logic                  hit_wr_ok;
   logic                  hit_screen;
   logic                  any_hit;
   logic                  ram_rd;       // cpu read served by the sram
   logic                  ext_rd;       // rom read served from outside

   // ------------------------------------------------------------
   // merge the quadrant results, only the hit slot contributes
   // ------------------------------------------------------------
   always_comb begin
      hits       = '0;
      hit_addr   = '0;
      hit_wr_ok  = 1'b0;
      hit_screen = 1'b0;
      for (int i = 0; i < SLOT_COUNT; i++) begin
         hits[i] = maps[i].hit;
         if (maps[i].hit) begin
            hit_addr   = hit_addr | maps[i].ram_addr;
            hit_wr_ok  = hit_wr_ok | maps[i].wr_ok;
            hit_screen = hit_screen | maps[i].contended;
         end
      end
   end

   assign any_hit = |hits;
   assign ram_rd  = any_hit && !bus.rd_n;
   assign ext_rd  = !boot_mode && inhibit_rom && !bus.mreq_n && !bus.rd_n &&
                    bus.a[CPU_AW-1 -: 2] == 2'b00;        // rom space, $0000-$3fff

   // sram side
   assign ram_a            = hit_addr;                   // zero when idle
   assign ram_rd_n         = !ram_rd;
   assign ram_wr_n         = !(any_hit && hit_wr_ok && !bus.wr_n);   // rom pages stay intact
   assign ram_q            = bus.din;
   assign access_to_screen = hit_screen;

   // ------------------------------------------------------------
   // cpu data out, external rom first, then sram, then registers
   // ------------------------------------------------------------
   always_comb begin
      dout = IDLE_DATA;
      oe   = 1'b0;
      if (ext_rd) begin
         dout = din_external;
         oe   = 1'b1;
      end else if (ram_rd) begin
         dout = ram_d;
         oe   = 1'b1;
      end else if (rdback_vld) begin
         dout = rdback;
         oe   = 1'b1;
      end
   end

   // evaluated once the quadrant outputs have settled in the time step
   always_comb begin
      a_one_hit : assert final ($onehot0(hits))
         else $error("more than one quadrant hit at once");
      a_no_overlap : assert final (bus.mreq_n || !(zreg.ior || zreg.iow))
         else $error("register access during a memory cycle");   // dout is shared
   end

endmodule

`default_nettype wire

/* hw/mem_manager.sv */
`default_nettype none

module mem_manager #(
   parameter bit PENTAGON_512K = 1'b0   // extend the $c000 bank to 512K
) (
   input  logic                        clk,
   input  logic                        mrst_n,

   // cpu side
   input  mem_pkg::cpu_bus_t           bus,
   output logic [7:0]                  dout,
   output logic                        oe,

   // core registers and option gates
   input  mem_pkg::zxreg_t             zreg,
   input  mem_pkg::mem_opts_t          opts,

   // external rom and sram
   input  logic                        inhibit_rom,
   input  logic [7:0]                  din_external,
   input  logic [7:0]                  ram_d,
   output logic [mem_pkg::RAM_AW-1:0]  ram_a,
   output logic                        ram_rd_n,
   output logic                        ram_wr_n,
   output logic [7:0]                  ram_q,

   // ula and machine state
   output logic                        access_to_screen,
   output logic [1:0]                  timing_mode,
   output logic                        disable_contention,
   output logic                        issue2_keyboard_enabled,
   output logic                        in_boot_mode,
   output logic                        in48kmode
);
   import mem_pkg::*;

   paging_t    pg;                       // shared paging state
   logic [7:0] rdback;
   logic       rdback_vld;
   slot_map_t  slot_maps [SLOT_COUNT];   // one entry per quadrant

   // ------------------------------------------------------------
   // registers
   // ------------------------------------------------------------
   paging_regs u_regs (
      .clk                     (clk),
      .mrst_n                  (mrst_n),
      .bus                     (bus),
      .zreg                    (zreg),
      .opts                    (opts),
      .pg                      (pg),
      .rdback                  (rdback),
      .rdback_vld              (rdback_vld),
      .timing_mode             (timing_mode),
      .disable_contention      (disable_contention),
      .issue2_keyboard_enabled (issue2_keyboard_enabled),
      .in_boot_mode            (in_boot_mode),
      .in48kmode               (in48kmode)
   );

   // ------------------------------------------------------------
   // one mapper per 16 KB quadrant
   // ------------------------------------------------------------
   for (genvar s = 0; s < SLOT_COUNT; s++) begin : g_slot
      quadrant_mapper #(
         .SLOT          (s),
         .PENTAGON_512K (PENTAGON_512K)
      ) u_map (
         .bus         (bus),
         .pg          (pg),
         .opts        (opts),
         .inhibit_rom (inhibit_rom),
         .map         (slot_maps[s])
      );
   end

   // sram strobes and cpu data mux
   bus_select u_sel (
      .bus              (bus),
      .zreg             (zreg),
      .maps             (slot_maps),
      .rdback           (rdback),
      .rdback_vld       (rdback_vld),
      .boot_mode        (pg.boot_mode),
      .inhibit_rom      (inhibit_rom),
      .din_external     (din_external),
      .ram_d            (ram_d),
      .ram_a            (ram_a),
      .ram_rd_n         (ram_rd_n),
      .ram_wr_n         (ram_wr_n),
      .ram_q            (ram_q),
      .dout             (dout),
      .oe               (oe),
      .access_to_screen (access_to_screen)
   );

endmodule

`default_nettype wire

/* dv/mem_manager_tb.sv */
`default_nettype none

module mem_manager_tb;
   import mem_pkg::*;

   localparam int          NFIELD  = 10;           // words per golden line
   localparam int          MAXVEC  = 64;
   localparam logic [31:0] DC_ADDR = 32'hFF_FFFF;  // ram_a not checked
   localparam logic [31:0] DC_BIT  = 32'hF;        // strobes or screen not checked

   logic              clk;
   logic              mrst_n;
   cpu_bus_t          bus;
   zxreg_t            zreg;
   mem_opts_t         opts;
   logic              inhibit_rom;
   logic [7:0]        din_external;
   logic [7:0]        ram_d;
   logic [RAM_AW-1:0] ram_a;
   logic              ram_rd_n;
   logic              ram_wr_n;
   logic [7:0]        ram_q;
   logic [7:0]        dout;
   logic              oe;
   logic              access_to_screen;
   logic [1:0]        timing_mode;
   logic              disable_contention;
   logic              issue2_keyboard_enabled;
   logic              in_boot_mode;
   logic              in48kmode;

   logic [31:0] golden [0:NFIELD*MAXVEC-1];
   logic [31:0] lfsr;
   logic [7:0]  conf_model;    // master configuration as software left it
   logic [1:0]  timing_model;
   logic        lock_model;    // $7ffd lock bit seen
   int          nvec;
   int          limit;
   int          cycles;
   int          cur_test;
   int          vec_err;       // mismatches in the current vector
   int          test_vecs;
   int          test_err;      // bad vectors in the current test
   int          errors;
   int          tests_run;
   int          tests_failed;

   mem_manager #(.PENTAGON_512K(1'b0)) uut (.*);

   initial begin
      clk = 1'b0;
      forever #2 clk = ~clk;
   end

   // galois form of x^32+x^22+x^2+x+1, shifting right
   function automatic logic [31:0] lfsr_next(input logic [31:0] s);
      lfsr_next = s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
   endfunction

   task automatic draw_byte(output logic [7:0] b);
      for (int k = 0; k < 8; k++) begin
         b[k] = lfsr[0];          // one step per bit
         lfsr = lfsr_next(lfsr);
      end
   endtask

   task automatic report_mismatch(input int v, input string what,
                                  input logic [31:0] got, input logic [31:0] exp);
      $display("FAILED t=%0t vector %0d %s: got %0h, expected %0h", $time, v, what, got, exp);
      vec_err++;
   endtask

   // ------------------------------------------------------------
   // one golden line onto the dut pins
   // ------------------------------------------------------------
   task automatic drive_vector(input int v);
      logic [31:0] op;
      logic [31:0] adr;
      logic [31:0] dat;
      op          = golden[v*NFIELD+1];
      adr         = golden[v*NFIELD+2];
      dat         = golden[v*NFIELD+3];
      vec_err     = 0;
      bus.a       = adr[15:0];
      bus.din     = dat[7:0];
      bus.mreq_n  = 1'b1;          // idle cycle unless the op says otherwise
      bus.iorq_n  = 1'b1;
      bus.rd_n    = 1'b1;
      bus.wr_n    = 1'b1;
      zreg.addr   = adr[7:0];
      zreg.ior    = 1'b0;
      zreg.iow    = 1'b0;
      opts        = golden[v*NFIELD+4][5:0];
      inhibit_rom = golden[v*NFIELD+5][0];
      draw_byte(ram_d);
      draw_byte(din_external);
      case (op)
         0: begin
            bus.iorq_n = 1'b0;    // port write
            bus.wr_n   = 1'b0;
         end
         1: zreg.iow = 1'b1;
         2: begin
            bus.mreq_n = 1'b0;
            bus.rd_n   = 1'b0;
         end
         3: begin
            bus.mreq_n = 1'b0;
            bus.wr_n   = 1'b0;
         end
         4: begin
            bus.iorq_n = 1'b0;    // port read
            bus.rd_n   = 1'b0;
         end
         5: zreg.ior = 1'b1;
         default: begin
            $display("vector %0d has an unknown operation %0h", v, op);
            vec_err++;
         end
      endcase
   endtask

   task automatic check_vector(input int v);
      logic [31:0] exp_a;
      logic [31:0] exp_st;
      logic [31:0] exp_do;
      logic [31:0] exp_scr;
      logic [7:0]  exp_byte;
      logic        exp_48k;
      exp_a   = golden[v*NFIELD+6];
      exp_st  = golden[v*NFIELD+7];
      exp_do  = golden[v*NFIELD+8];
      exp_scr = golden[v*NFIELD+9];
      exp_48k = lock_model || opts.disable_7ffd;
      if (exp_do[9:8] == 2'b10)
         exp_byte = ram_d;               // sram read data
      else if (exp_do[9:8] == 2'b11)
         exp_byte = din_external;        // external rom data
      else
         exp_byte = exp_do[7:0];
      if (exp_a != DC_ADDR && ram_a != exp_a[RAM_AW-1:0])
         report_mismatch(v, "ram_a", ram_a, exp_a);
      if (exp_st != DC_BIT && {ram_rd_n, ram_wr_n} != exp_st[1:0])
         report_mismatch(v, "ram_rd_n/ram_wr_n", {ram_rd_n, ram_wr_n}, exp_st);
      if (oe != (exp_do[9:8] != 2'b00))
         report_mismatch(v, "oe", oe, exp_do[9:8] != 2'b00);
      if (dout != exp_byte)
         report_mismatch(v, "dout", dout, exp_byte);
      if (exp_scr != DC_BIT && access_to_screen != exp_scr[0])
         report_mismatch(v, "access_to_screen", access_to_screen, exp_scr);
      if (golden[v*NFIELD+1] == 3 && ram_q != golden[v*NFIELD+3][7:0])
         report_mismatch(v, "ram_q", ram_q, golden[v*NFIELD+3]);

      // machine state from the master configuration and the $7ffd lock
      if (timing_mode != timing_model)
         report_mismatch(v, "timing_mode", timing_mode, timing_model);
      if (disable_contention != conf_model[5])
         report_mismatch(v, "disable_contention", disable_contention, conf_model[5]);
      if (issue2_keyboard_enabled != conf_model[3])
         report_mismatch(v, "issue2_keyboard_enabled", issue2_keyboard_enabled,
                         conf_model[3]);
      if (in_boot_mode != !conf_model[7])   // boot phase lasts until the freeze
         report_mismatch(v, "in_boot_mode", in_boot_mode, !conf_model[7]);
      if (in48kmode != exp_48k)
         report_mismatch(v, "in48kmode", in48kmode, exp_48k);
      test_vecs++;
      errors = errors + vec_err;
      if (vec_err != 0)
         test_err++;
   endtask

   // register writes land at the coming rising edge, seen from the next vector on
   task automatic track_registers(input int v);
      logic [31:0] op;
      logic [31:0] adr;
      logic [7:0]  dat;
      op  = golden[v*NFIELD+1];
      adr = golden[v*NFIELD+2];
      dat = golden[v*NFIELD+3][7:0];
      if (op == 1 && adr[7:0] == MASTERCONF_ADDR) begin
         conf_model[6:1] = dat[6:1];
         timing_model    = {dat[6], dat[4]};
         if (!conf_model[7]) begin   // freeze and boot bits read-only once frozen
            conf_model[7] = dat[7];
            conf_model[0] = dat[0];
         end
      end
      if (op == 0 && adr[15:0] == 16'h7FFD && !opts.disable_7ffd && !lock_model)
         lock_model = dat[5];
   endtask

   task automatic close_test(input int t);
      tests_run++;
      if (test_err == 0) begin
         $display("test %0d passed, %0d vectors", t, test_vecs);
      end else begin
         $display("test %0d failed, %0d of %0d vectors wrong", t, test_err, test_vecs);
         tests_failed++;
      end
      test_vecs = 0;
      test_err  = 0;
   endtask

   // ------------------------------------------------------------
   // main sequence
   // ------------------------------------------------------------
   initial begin
      mrst_n       = 1'b0;
      bus          = '0;
      bus.mreq_n   = 1'b1;
      bus.iorq_n   = 1'b1;
      bus.rd_n     = 1'b1;
      bus.wr_n     = 1'b1;
      zreg         = '0;
      opts         = '0;
      inhibit_rom  = 1'b0;
      din_external = 8'h00;
      ram_d        = 8'h00;
      lfsr         = 32'h328b;
      conf_model   = 8'h01;              // boot mode after reset
      timing_model = 2'b01;
      lock_model   = 1'b0;
      errors       = 0;
      tests_run    = 0;
      tests_failed = 0;
      test_vecs    = 0;
      test_err     = 0;
      for (int i = 0; i < NFIELD*MAXVEC; i++)
         golden[i] = '0;                 // a short or missing file ends the list early
      $readmemh("dv/golden_memmap.txt", golden);
      nvec = 0;
      while (nvec < MAXVEC && golden[nvec*NFIELD] != 0)
         nvec++;
      limit = 3*nvec + 50;
      repeat (8) @(posedge clk);
      @(negedge clk);
      mrst_n = 1'b1;
      if (nvec == 0) begin
         $display("no vectors read from dv/golden_memmap.txt");
      end else begin
         cur_test = golden[0];
         for (int v = 0; v < nvec; v++) begin
            if (golden[v*NFIELD] != cur_test) begin
               close_test(cur_test);
               cur_test = golden[v*NFIELD];
            end
            @(negedge clk);
            drive_vector(v);
            #1;                          // just before the next rising edge
            check_vector(v);
            track_registers(v);
         end
         close_test(cur_test);
      end
      $display("tests %0d, failed %0d, mismatches %0d", tests_run, tests_failed, errors);
      if (nvec > 0 && tests_failed == 0 && errors == 0) begin
         $display(">>> PASS");
      end else begin
         $display(">>> FAIL");
      end
      $finish;
   end

   // watchdog, three cycles per vector plus setup margin
   initial begin
      cycles = 0;
      wait (limit > 0);
      while (cycles < limit) begin
         @(posedge clk);
         cycles++;
      end
      $display("timeout after %0d cycles, run did not finish", cycles);
      $display(">>> FAIL");
      $finish;
   end

endmodule

`default_nettype wire

/* list.f */
hw/mem_pkg.sv
hw/paging_regs.sv
hw/quadrant_mapper.sv
hw/bus_select.sv
hw/mem_manager.sv
dv/mem_manager_tb.sv

/* dv/golden_memmap.txt */
// test op addr data opts inh | ram_a strobes(rd_n,wr_n) oe_dout screen, F/FFFFFF = not checked
// op 0 io wr, 1 reg wr, 2 mem rd, 3 mem wr, 4 io rd, 5 reg rd; oe_dout 200 = ram_d, 300 = external
1 5 0000 00 00 0 FFFFFF 3 101 F
1 2 4123 00 00 0 014123 1 200 0
1 2 8010 00 00 0 008010 1 200 0
1 2 0000 00 00 0 FFFFFF 3 0FF F
1 1 0001 1A 00 0 FFFFFF 3 0FF F
1 5 0001 00 00 0 FFFFFF 3 11A F
1 2 C005 00 00 0 068005 1 200 0
1 3 C100 55 00 0 068100 2 0FF 0
5 1 0000 80 00 0 FFFFFF 3 0FF F
5 5 0000 00 00 0 FFFFFF 3 180 F
5 1 0000 01 00 0 FFFFFF 3 0FF F
5 5 0000 00 00 0 FFFFFF 3 180 F
5 2 0200 00 00 1 FFFFFF 3 300 0
5 2 0200 00 00 0 020200 1 200 0
5 2 4000 00 00 0 014000 1 200 1
3 0 1FFD 01 00 0 FFFFFF 3 0FF F
3 2 0010 00 00 0 000010 1 200 0
3 3 4010 11 00 0 004010 2 0FF 0
3 2 8010 00 00 0 008010 1 200 0
3 2 C010 00 00 0 00C010 1 200 0
3 0 1FFD 03 00 0 FFFFFF 3 0FF F
3 3 0020 22 00 0 010020 2 0FF 0
3 2 4020 00 00 0 014020 1 200 0
3 2 8020 00 00 0 018020 1 200 0
3 2 C020 00 00 0 01C020 1 200 0
3 0 1FFD 05 00 0 FFFFFF 3 0FF F
3 2 0030 00 00 0 010030 1 200 0
3 2 4030 00 00 0 014030 1 200 0
3 2 8030 00 00 0 018030 1 200 0
3 3 C030 33 00 0 00C030 2 0FF 0
3 0 1FFD 07 00 0 FFFFFF 3 0FF F
3 2 0040 00 00 0 010040 1 200 0
3 3 4040 44 00 0 01C040 2 0FF 0
3 2 8040 00 00 0 018040 1 200 0
3 2 C040 00 00 0 00C040 1 200 0
3 0 1FFD 00 00 0 FFFFFF 3 0FF F
4 0 00F4 04 02 0 FFFFFF 3 0FF F
4 4 00F4 00 02 0 FFFFFF 3 104 F
4 2 4100 00 03 0 074100 1 200 0
4 2 6100 00 03 0 016100 1 200 1
4 2 4100 00 02 0 064100 1 200 0
4 0 00F4 00 02 0 FFFFFF 3 0FF F
2 0 7FFD 13 00 0 FFFFFF 3 0FF F
2 2 C200 00 00 0 00C200 1 200 1
2 2 0100 00 00 0 024100 1 200 0
2 3 0100 AA 00 0 FFFFFF 3 0FF 0
2 0 7FFD 24 00 0 FFFFFF 3 0FF F
2 2 C000 00 00 0 010000 1 200 0
2 0 7FFD 07 00 0 FFFFFF 3 0FF F
2 2 C001 00 00 0 010001 1 200 0
2 2 0000 00 00 0 020000 1 200 0
0 0 0000 00 00 0 000000 0 000 0
